// File: dv/arena_cases.txt
# left right attack (2-bit binary, bit 0 = left fighter), frames in the step, then at step end:
# posx_l posx_r state_l state_r (0 idle 1 fwd 2 back 3 start 4 active 5 recover) health_l health_r ko
00 00 00   2  210 420 0 0 100 100 0
00 01 00  10  255 420 1 0 100 100 0
00 10 00   4  260 435 0 2 100 100 0
11 11 00   6  235 465 2 2 100 100 0
00 00 00   2  230 470 0 0 100 100 0
01 10 00  45   50 490 2 2 100 100 0
00 00 00   1   50 490 0 0 100 100 0
00 01 01   6   50 490 3 0 100 100 0
00 01 01   1   50 490 4 0 100 100 0
00 01 01   2   50 490 4 0 100 100 0
00 01 01   1   50 490 5 0 100 100 0
00 01 01  16   50 490 5 0 100 100 0
00 01 01   1   50 490 0 0 100 100 0
10 01 00  41  250 290 1 1 100 100 0
00 00 00   1  255 285 0 0 100 100 0
00 00 01   8  255 285 4 0 100  90 0
00 00 00  19  255 285 0 0 100  90 0
00 00 10  27  255 285 0 0  90  90 0
00 00 01 230  255 285 5 0  90   0 1
00 00 10   8  255 285 5 4  90   0 1
00 00 00  19  255 285 0 0  90   0 1

// File: files.f
design/fight_pkg.sv
design/button_if.sv
design/fighter_if.sv
design/input_conditioner.sv
design/fighter.sv
design/hit_judge.sv
design/arena_top.sv
dv/arena_sva.sv
dv/arena_tb.sv

// File: Bender.yml
package:
  name: arena_core

sources:
  # game logic
  - files:
      - design/fight_pkg.sv
      - design/button_if.sv
      - design/fighter_if.sv
      - design/input_conditioner.sv
      - design/fighter.sv
      - design/hit_judge.sv
      - design/arena_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - dv/arena_sva.sv
      - dv/arena_tb.sv

// File: dv/arena_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arena_tb import fight_pkg::*; ();

  localparam int    CLK_PERIOD = 8;
  localparam int    RST_CYCLES = 5;
  localparam int    MAX_CASES  = 64;
  localparam string CASE_FILE  = "dv/arena_cases.txt";

  logic                clk;
  logic                rst;
  logic [1:0]          left;
  logic [1:0]          right;
  logic [1:0]          attack;
  logic [POS_W-1:0]    posx_l;
  logic [POS_W-1:0]    posx_r;
  fighter_state_t      state_l;
  fighter_state_t      state_r;
  logic [HEALTH_W-1:0] health_l;
  logic [HEALTH_W-1:0] health_r;
  logic [1:0]          hit;
  logic                ko;

  // one entry per case line
  logic [1:0]          c_left     [MAX_CASES];
  logic [1:0]          c_right    [MAX_CASES];
  logic [1:0]          c_attack   [MAX_CASES];
  int                  c_frames   [MAX_CASES];
  logic [POS_W-1:0]    c_posx_l   [MAX_CASES];
  logic [POS_W-1:0]    c_posx_r   [MAX_CASES];
  fighter_state_t      c_state_l  [MAX_CASES];
  fighter_state_t      c_state_r  [MAX_CASES];
  logic [HEALTH_W-1:0] c_health_l [MAX_CASES];
  logic [HEALTH_W-1:0] c_health_r [MAX_CASES];
  logic                c_ko       [MAX_CASES];
  int                  n_cases;
  int                  total_frames;
  int                  hit_cnt [2];
  bit                  loaded = 1'b0;

  arena_top DUT (
    .clk      (clk),
    .rst      (rst),
    .left     (left),
    .right    (right),
    .attack   (attack),
    .posx_l   (posx_l),
    .posx_r   (posx_r),
    .state_l  (state_l),
    .state_r  (state_r),
    .health_l (health_l),
    .health_r (health_r),
    .hit      (hit),
    .ko       (ko)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // hit is a one-clock pulse, so each one is seen by exactly one falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (hit[0])
        hit_cnt[0] = hit_cnt[0] + 1;
      if (hit[1])
        hit_cnt[1] = hit_cnt[1] + 1;
    end
  end

  always @(negedge clk) begin
    if (DUT.u_sva.fail_cnt != 0) begin
      $display("an assertion failed before t=%0t", $time);
      stop_run();
    end
  end

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pos(input string name, input logic [POS_W-1:0] exp,
                           input logic [POS_W-1:0] act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_state(input string name, input fighter_state_t exp,
                             input fighter_state_t act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %s(%0d) actual %s(%0d)", $time, name,
               exp.name(), exp, act.name(), act);
      stop_run();
    end
  endtask

  task automatic check_health(input string name, input logic [HEALTH_W-1:0] exp,
                              input logic [HEALTH_W-1:0] act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_run();
    end
  endtask

  // landed hits needed to bring health down from full
  function automatic int hits_implied(input logic [HEALTH_W-1:0] health);
    return (HEALTH_MAX - int'(health) + HIT_DAMAGE - 1) / HIT_DAMAGE;
  endfunction

  task automatic load_cases();
    int    fd;
    int    n;
    int    v_l, v_r, v_a, v_fr, v_pl, v_pr, v_sl, v_sr, v_hl, v_hr, v_ko;
    string line;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the case file %s", CASE_FILE);
      stop_run();
    end
    n_cases      = 0;
    total_frames = 0;
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0)
        break;
      if (line.len() < 2 || line[0] == "#")
        continue;  // blank or column notes
      n = $sscanf(line, "%b %b %b %d %d %d %d %d %d %d %d", v_l, v_r, v_a, v_fr,
                  v_pl, v_pr, v_sl, v_sr, v_hl, v_hr, v_ko);
      if (n != 11 || n_cases >= MAX_CASES) begin
        $display("case file line %0d could not be used: %s", n_cases, line);
        stop_run();
      end
      c_left[n_cases]     = 2'(v_l);
      c_right[n_cases]    = 2'(v_r);
      c_attack[n_cases]   = 2'(v_a);
      c_frames[n_cases]   = v_fr;
      c_posx_l[n_cases]   = POS_W'(v_pl);
      c_posx_r[n_cases]   = POS_W'(v_pr);
      c_state_l[n_cases]  = fighter_state_t'(v_sl);
      c_state_r[n_cases]  = fighter_state_t'(v_sr);
      c_health_l[n_cases] = HEALTH_W'(v_hl);
      c_health_r[n_cases] = HEALTH_W'(v_hr);
      c_ko[n_cases]       = v_ko[0];
      total_frames        = total_frames + v_fr;
      n_cases++;
    end
    $fclose(fd);
  endtask

  task automatic check_step(input int i);
    check_pos("posx_l", c_posx_l[i], posx_l);
    check_pos("posx_r", c_posx_r[i], posx_r);
    check_state("state_l", c_state_l[i], state_l);
    check_state("state_r", c_state_r[i], state_r);
    check_health("health_l", c_health_l[i], health_l);
    check_health("health_r", c_health_r[i], health_r);
    check_flag("ko", c_ko[i], ko);
    check_count("hit[0] pulses", hits_implied(c_health_r[i]), hit_cnt[0]); // left lands on right
    check_count("hit[1] pulses", hits_implied(c_health_l[i]), hit_cnt[1]);
  endtask

  initial begin
    rst        = 1'b1;
    left       = 2'b00;
    right      = 2'b00;
    attack     = 2'b00;
    hit_cnt[0] = 0;
    hit_cnt[1] = 0;
    load_cases();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // whole frames per step keep the strobe phase fixed across steps
    for (int i = 0; i < n_cases; i++) begin
      left   = c_left[i];
      right  = c_right[i];
      attack = c_attack[i];
      repeat (c_frames[i] * FRAME_DIV) @(posedge clk);
      @(negedge clk);
      check_step(i);
    end
    if (DUT.u_sva.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("%0d assertion failures", DUT.u_sva.fail_cnt);
      stop_run();
    end
  end

  initial begin
    wait (loaded);
    #(total_frames * FRAME_DIV * CLK_PERIOD + 200 * CLK_PERIOD);
    $display("watchdog expired, the cases did not finish in %0d frames", total_frames);
    stop_run();
  end

endmodule

`default_nettype wire

// File: dv/arena_sva.sv
`timescale 1ns/1ps
`default_nettype none

module arena_sva import fight_pkg::*; (
  input logic                clk,
  input logic                rst,
  input logic [POS_W-1:0]    posx_l,
  input logic [POS_W-1:0]    posx_r,
  input logic [HEALTH_W-1:0] health_l,
  input logic [HEALTH_W-1:0] health_r,
  input logic [1:0]          hit
);

  int fail_cnt = 0;

  // one pulse per landed attack
  a_hit_single: assert property (@(posedge clk) disable iff (rst)
    (hit & $past(hit)) == 2'b00)
    else begin
      $error("hit bit high on two consecutive clocks");
      fail_cnt++;
    end

  a_health_down: assert property (@(posedge clk) disable iff (rst)
    (health_l <= $past(health_l)) && (health_r <= $past(health_r)))
    else begin
      $error("health rose outside reset");
      fail_cnt++;
    end

  a_posx_range: assert property (@(posedge clk) disable iff (rst)
    (posx_l >= POS_W'(X_MIN)) && (posx_l <= POS_W'(X_MAX)) &&
    (posx_r >= POS_W'(X_MIN)) && (posx_r <= POS_W'(X_MAX)))
    else begin
      $error("fighter position left the arena");
      fail_cnt++;
    end

endmodule

bind arena_top arena_sva u_sva (.*);

`default_nettype wire

// File: design/arena_top.sv
`timescale 1ns/1ps
`default_nettype none

module arena_top import fight_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [1:0]          left,    // bit 0 is the left fighter
  input  logic [1:0]          right,
  input  logic [1:0]          attack,
  output logic [POS_W-1:0]    posx_l,
  output logic [POS_W-1:0]    posx_r,
  output fighter_state_t      state_l,
  output fighter_state_t      state_r,
  output logic [HEALTH_W-1:0] health_l,
  output logic [HEALTH_W-1:0] health_r,
  output logic [1:0]          hit,
  output logic                ko
);

  button_if  btn_bus [N_FIGHTERS] ();
  fighter_if fgt_bus [N_FIGHTERS] ();

  input_conditioner u_cond (
    .clk    (clk),
    .rst    (rst),
    .left   (left),
    .right  (right),
    .attack (attack),
    .btn    (btn_bus)
  );

  for (genvar g = 0; g < N_FIGHTERS; g++) begin : g_fighter
    fighter #(
      .SIDE (1'(g))
    ) u_fighter (
      .clk (clk),
      .rst (rst),
      .btn (btn_bus[g]),
      .fo  (fgt_bus[g])
    );
  end

  hit_judge u_judge (
    .clk      (clk),
    .rst      (rst),
    .fi       (fgt_bus),
    .health_l (health_l),
    .health_r (health_r),
    .hit      (hit),
    .ko       (ko)
  );

  // fighter outputs to plain ports
  assign posx_l  = fgt_bus[0].posx;
  assign posx_r  = fgt_bus[1].posx;
  assign state_l = fgt_bus[0].state;
  assign state_r = fgt_bus[1].state;

endmodule

`default_nettype wire

// File: design/hit_judge.sv
`timescale 1ns/1ps
`default_nettype none

module hit_judge import fight_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  fighter_if.dst              fi [N_FIGHTERS],
  output logic [HEALTH_W-1:0] health_l,
  output logic [HEALTH_W-1:0] health_r,
  output logic [1:0]          hit,
  output logic                ko
);

  wire  [N_FIGHTERS-1:0] det;      // attacker g touches the other body
  wire  [N_FIGHTERS-1:0] swinging; // attacker g still in its active phase
  logic [N_FIGHTERS-1:0] landed;
  logic [N_FIGHTERS-1:0] fresh;
  logic [HEALTH_W-1:0]   health     [N_FIGHTERS];
  logic [HEALTH_W-1:0]   health_nxt [N_FIGHTERS];
  logic                  any_zero;

  // inclusive interval overlap
  function automatic logic overlaps(input logic [POS_W-1:0] a1, input logic [POS_W-1:0] a2,
                                    input logic [POS_W-1:0] b1, input logic [POS_W-1:0] b2);
    return (a1 <= b2) && (b1 <= a2);
  endfunction

  for (genvar g = 0; g < N_FIGHTERS; g++) begin : g_atk
    assign det[g] = fi[g].atk_active &&
                    overlaps(fi[g].hit_x1, fi[g].hit_x2,
                             fi[N_FIGHTERS-1-g].hurt_x1, fi[N_FIGHTERS-1-g].hurt_x2);
    assign swinging[g] = (fi[g].state == ST_ATK_ACTIVE);
  end

  // first contact of this attack only
  assign fresh = det & ~landed & {N_FIGHTERS{~ko}};

  always_comb begin
    any_zero = 1'b0;
    for (int i = 0; i < N_FIGHTERS; i++) begin
      health_nxt[i] = health[i];
      if (fresh[N_FIGHTERS-1-i]) begin
        if (health[i] < HEALTH_W'(HIT_DAMAGE))
          health_nxt[i] = '0;  // saturate
        else
          health_nxt[i] = health[i] - HEALTH_W'(HIT_DAMAGE);
      end
      if (health_nxt[i] == '0)
        any_zero = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      landed <= '0;
      hit    <= '0;
      ko     <= 1'b0;
      health <= '{default: HEALTH_W'(HEALTH_MAX)};
    end else begin
      landed <= (landed | det) & swinging;  // clears once the active phase ends
      hit    <= fresh;
      if (!ko) begin
        health <= health_nxt;
        ko     <= any_zero;
      end
    end
  end

  assign health_l = health[0];
  assign health_r = health[1];

endmodule

`default_nettype wire

// File: design/fighter.sv
`timescale 1ns/1ps
`default_nettype none

module fighter import fight_pkg::*; #(
  parameter bit SIDE = 1'b0  // 0 left, 1 right
) (
  input  logic   clk,
  input  logic   rst,
  button_if.dst  btn,
  fighter_if.src fo
);

  fighter_state_t     state;
  fighter_state_t     state_nxt;
  logic [POS_W-1:0]   posx;
  logic [POS_W-1:0]   posx_nxt;
  logic [PHASE_W-1:0] phase_cnt;
  logic               in_atk;
  logic               moving;
  logic               step_up;

  assign in_atk = (state == ST_ATK_START) || (state == ST_ATK_ACTIVE) ||
                  (state == ST_ATK_RECOVER);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE, ST_FWD, ST_BACK: begin
        if (btn.attack)
          state_nxt = ST_ATK_START;  // attack wins over movement
        else if (btn.left && btn.right)
          state_nxt = ST_BACK;
        else if (btn.left)
          state_nxt = SIDE ? ST_FWD : ST_BACK;
        else if (btn.right)
          state_nxt = SIDE ? ST_BACK : ST_FWD;
        else
          state_nxt = ST_IDLE;
      end
      ST_ATK_START: begin
        if (phase_cnt == PHASE_W'(STARTUP_FRAMES - 1))
          state_nxt = ST_ATK_ACTIVE;
      end
      ST_ATK_ACTIVE: begin
        if (phase_cnt == PHASE_W'(ACTIVE_FRAMES - 1))
          state_nxt = ST_ATK_RECOVER;
      end
      ST_ATK_RECOVER: begin
        if (phase_cnt == PHASE_W'(RECOVER_FRAMES - 1))
          state_nxt = ST_IDLE;
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // forward is +x for the left fighter, -x for the right one
  assign moving  = (state == ST_FWD) || (state == ST_BACK);
  assign step_up = (state == ST_FWD) ^ SIDE;

  always_comb begin
    posx_nxt = posx;
    if (moving) begin
      if (step_up) begin
        if (posx > POS_W'(X_MAX - SPEED))
          posx_nxt = POS_W'(X_MAX);
        else
          posx_nxt = posx + POS_W'(SPEED);
      end else begin
        if (posx < POS_W'(X_MIN + SPEED))
          posx_nxt = POS_W'(X_MIN);
        else
          posx_nxt = posx - POS_W'(SPEED);
      end
    end
  end

  // everything advances on the frame strobe only
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= ST_IDLE;
      posx      <= SIDE ? POS_W'(X_START_R) : POS_W'(X_START_L);
      phase_cnt <= '0;
    end else if (btn.frame) begin
      state <= state_nxt;
      posx  <= posx_nxt;
      if (in_atk && (state_nxt == state))
        phase_cnt <= phase_cnt + 1'b1;
      else
        phase_cnt <= '0;  // restart on every phase change
    end
  end

  assign fo.posx       = posx;
  assign fo.state      = state;
  assign fo.atk_active = (state == ST_ATK_ACTIVE);

  // right side is the left-side box mirrored inside the sprite width
  assign fo.hit_x1  = posx + (SIDE ? POS_W'(BOX_SPAN - HIT_FAR)   : POS_W'(HIT_NEAR));
  assign fo.hit_x2  = posx + (SIDE ? POS_W'(BOX_SPAN - HIT_NEAR)  : POS_W'(HIT_FAR));
  assign fo.hurt_x1 = posx + (SIDE ? POS_W'(BOX_SPAN - HURT_FAR)  : POS_W'(HURT_NEAR));
  assign fo.hurt_x2 = posx + (SIDE ? POS_W'(BOX_SPAN - HURT_NEAR) : POS_W'(HURT_FAR));

endmodule

`default_nettype wire

// File: design/input_conditioner.sv
`timescale 1ns/1ps
`default_nettype none

module input_conditioner import fight_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [1:0] left,
  input  logic [1:0] right,
  input  logic [1:0] attack,
  button_if.src      btn [N_FIGHTERS]
);

  logic [1:0] left_s1, left_s2;
  logic [1:0] right_s1, right_s2;
  logic [1:0] attack_s1, attack_s2;
  logic [$clog2(FRAME_DIV)-1:0] frame_cnt;
  logic frame;

  // two-flop sync, all six buttons
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      left_s1   <= '0;
      left_s2   <= '0;
      right_s1  <= '0;
      right_s2  <= '0;
      attack_s1 <= '0;
      attack_s2 <= '0;
    end else begin
      left_s1   <= left;
      left_s2   <= left_s1;
      right_s1  <= right;
      right_s2  <= right_s1;
      attack_s1 <= attack;
      attack_s2 <= attack_s1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      frame_cnt <= '0;
    else if (frame)
      frame_cnt <= '0;
    else
      frame_cnt <= frame_cnt + 1'b1;
  end

  assign frame = (frame_cnt == ($clog2(FRAME_DIV))'(FRAME_DIV - 1)); // last clock of the frame

  for (genvar g = 0; g < N_FIGHTERS; g++) begin : g_player
    assign btn[g].left   = left_s2[g];
    assign btn[g].right  = right_s2[g];
    assign btn[g].attack = attack_s2[g];
    assign btn[g].frame  = frame;    // same phase for both players
  end

endmodule

`default_nettype wire

// File: design/fighter_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fighter_if import fight_pkg::*; ();

  logic [POS_W-1:0] posx;
  fighter_state_t   state;
  logic             atk_active;
  logic [POS_W-1:0] hit_x1;   // attack box, inclusive
  logic [POS_W-1:0] hit_x2;
  logic [POS_W-1:0] hurt_x1;  // body box, inclusive
  logic [POS_W-1:0] hurt_x2;

  modport src (
    output posx, state, atk_active,
    output hit_x1, hit_x2,
    output hurt_x1, hurt_x2
  );

  modport dst (
    input posx, state, atk_active,
    input hit_x1, hit_x2,
    input hurt_x1, hurt_x2
  );

endinterface

`default_nettype wire

// File: design/button_if.sv
`timescale 1ns/1ps
`default_nettype none

// one player's conditioned buttons
interface button_if ();

  logic left;    // level
  logic right;   // level
  logic attack;  // level
  logic frame;   // one clock per frame

  modport src (
    output left,
    output right,
    output attack,
    output frame
  );

  modport dst (
    input left,
    input right,
    input attack,
    input frame
  );

endinterface

`default_nettype wire

// File: design/fight_pkg.sv
`default_nettype none

package fight_pkg;

  // fighter count, one per side
  localparam int N_FIGHTERS = 2;

  // x coordinates and health
  localparam int POS_W    = 10;
  localparam int HEALTH_W = 7;

  // frame strobe, one per FRAME_DIV clocks
  localparam int FRAME_DIV = 4;

  // movement
  localparam int SPEED     = 5;   // pixels per frame
  localparam int X_MIN     = 50;
  localparam int X_MAX     = 490;
  localparam int X_START_L = 210;
  localparam int X_START_R = 420;

  // box offsets from posx, left-side view
  localparam int BOX_SPAN  = 150; // sprite width, used to mirror the right side
  localparam int HIT_NEAR  = 35;
  localparam int HIT_FAR   = 113;
  localparam int HURT_NEAR = 37;
  localparam int HURT_FAR  = 86;

  // attack phase lengths in frames
  localparam int STARTUP_FRAMES = 6;
  localparam int ACTIVE_FRAMES  = 3;
  localparam int RECOVER_FRAMES = 17;
  localparam int PHASE_W        = 5;  // holds RECOVER_FRAMES - 1

  // damage model
  localparam int HEALTH_MAX = 100;
  localparam int HIT_DAMAGE = 10;

  // fighter FSM states
  typedef enum logic [3:0] {
    ST_IDLE        = 4'd0,
    ST_FWD         = 4'd1,
    ST_BACK        = 4'd2,
    ST_ATK_START   = 4'd3,
    ST_ATK_ACTIVE  = 4'd4,
    ST_ATK_RECOVER = 4'd5
  } fighter_state_t;

endpackage

`default_nettype wire
